/* design/l1i_dir_consts.svh */
`ifndef L1I_DIR_CONSTS_SVH
`define L1I_DIR_CONSTS_SVH

////////////////////
// directory geometry
////////////////////

// number of sets which equals 2 ** L1I_INDEX_W
`define L1I_SETS     128

// set index width
`define L1I_INDEX_W  7

// tag width with one tag per way and set
`define L1I_TAG_W    28

// total ways split over two banks of two
`define L1I_WAYS     4

// command queue depth and credits held by the requester after reset
`define L1I_CREDITS  4

// hit code width made of one hit flag plus the way number
`define L1I_HIT_W    3

`endif

/* design/l1i_dir_pkg.sv */
`include "l1i_dir_consts.svh"

package l1i_dir_pkg;

   ////////////////////
   // command opcodes
   ////////////////////

   typedef enum logic [1:0] {
      op_query      = 2'd0,
      op_allocate   = 2'd1,
      op_deallocate = 2'd2,
      op_invalidate = 2'd3
   } dir_op_t;

   ////////////////////
   // hit code
   ////////////////////

   // hit is set only when exactly one way matched
   // an all-zero code covers both a miss and a multiple match
   typedef struct packed {
      logic                  hit;
      logic [`L1I_HIT_W-2:0] way;
   } hit_code_t;

endpackage

/* design/l1i_tag_bank.sv */
`timescale 1ns/1ps
`include "l1i_dir_consts.svh"

module l1i_tag_bank (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rd_en,
   input  logic [1:0]              wr_en,
   input  logic [`L1I_INDEX_W-1:0] addr,
   input  logic [`L1I_TAG_W-1:0]   wr_tag,
   input  logic                    wr_valid,
   input  logic [`L1I_TAG_W-1:0]   cmp_tag,
   output logic [1:0]              match
);

   localparam int BANK_WAYS = 2;

   // read stage that is captured together with the address
   logic                    rd_stage;
   logic [`L1I_INDEX_W-1:0] rd_addr;
   logic [`L1I_TAG_W-1:0]   rd_cmp_tag;

   // stored entries of the set being read
   logic [`L1I_TAG_W-1:0]   rd_tag [BANK_WAYS];
   logic [BANK_WAYS-1:0]    rd_vld;

   logic [BANK_WAYS-1:0]    way_hit;

   ////////////////////
   // read address stage
   ////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rd_stage <= 1'b0;
      end
      else
      begin
         rd_stage <= rd_en;
      end
   end

   // the compare tag travels with the address so it lines up with the entries
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_addr    <= addr;
         rd_cmp_tag <= cmp_tag;
      end
   end

   ////////////////////
   // per-way storage
   ////////////////////

   for (genvar w = 0; w < BANK_WAYS; w++)
   begin : g_way
      logic [`L1I_TAG_W-1:0] tag_mem [`L1I_SETS];
      logic                  vld_mem [`L1I_SETS];

      always_ff @(posedge clk)
      begin
         if (wr_en[w])
         begin
            tag_mem[addr] <= wr_tag;
            vld_mem[addr] <= wr_valid;
         end
      end

      // entries appear one cycle after the read was issued
      assign rd_tag[w] = tag_mem[rd_addr];
      assign rd_vld[w] = vld_mem[rd_addr];

      assign way_hit[w] = rd_vld[w] && (rd_tag[w] == rd_cmp_tag);
   end

   ////////////////////
   // match register
   ////////////////////

   // match keeps the last compare result between reads
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         match <= '0;
      end
      else if (rd_stage)
      begin
         match <= way_hit;
      end
   end

endmodule

/* design/l1i_dir_ctrl.sv */
`timescale 1ns/1ps
`include "l1i_dir_consts.svh"

module l1i_dir_ctrl
   import l1i_dir_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         cmd_valid,
   input  dir_op_t                      cmd_op,
   input  logic [`L1I_INDEX_W-1:0]      cmd_index,
   input  logic [$clog2(`L1I_WAYS)-1:0] cmd_way,
   input  logic [`L1I_TAG_W-1:0]        cmd_tag,
   output logic                         credit_return,
   output logic                         ready,
   output logic                         rd_en,
   output logic [1:0]                   wr_en_lo,
   output logic [1:0]                   wr_en_hi,
   output logic [`L1I_INDEX_W-1:0]      addr,
   output logic [`L1I_TAG_W-1:0]        wr_tag,
   output logic                         wr_valid,
   output logic [`L1I_TAG_W-1:0]        cmp_tag,
   input  logic [1:0]                   match_lo,
   input  logic [1:0]                   match_hi,
   output logic                         resp_valid,
   output hit_code_t                    resp_hit
);

   localparam int WAY_W = $clog2(`L1I_WAYS);
   localparam int PTR_W = $clog2(`L1I_CREDITS);
   localparam int CNT_W = $clog2(`L1I_CREDITS + 1);
   localparam int SWEEP_LAST = `L1I_SETS - 1;
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`L1I_CREDITS - 1);

   typedef enum logic [2:0] {
      st_reset,
      st_init,
      st_idle,
      st_read,
      st_dealloc
   } state_t;

   state_t state;

   // command queue
   dir_op_t                 q_op    [`L1I_CREDITS];
   logic [`L1I_INDEX_W-1:0] q_index [`L1I_CREDITS];
   logic [WAY_W-1:0]        q_way   [`L1I_CREDITS];
   logic [`L1I_TAG_W-1:0]   q_tag   [`L1I_CREDITS];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [CNT_W-1:0]        q_count;

   dir_op_t                 head_op;
   logic [`L1I_INDEX_W-1:0] head_index;
   logic [WAY_W-1:0]        head_way;
   logic [`L1I_TAG_W-1:0]   head_tag;
   logic                    issue;

   logic [`L1I_INDEX_W-1:0] sweep_idx;
   logic [`L1I_INDEX_W-1:0] dealloc_index;
   logic [`L1I_WAYS-1:0]    dealloc_ways;
   logic [`L1I_WAYS-1:0]    wr_en_all;

   // response shift register where bit 0 is one cycle after issue
   logic [1:0]              pipe_vld;
   logic [1:0]              pipe_dealloc;

   logic [`L1I_WAYS-1:0]    match_all;
   hit_code_t               hit_enc;
   hit_code_t               hit_hold;

   ////////////////////
   // command queue
   ////////////////////

   assign head_op    = q_op[rd_ptr];
   assign head_index = q_index[rd_ptr];
   assign head_way   = q_way[rd_ptr];
   assign head_tag   = q_tag[rd_ptr];

   // only the idle state issues, so nothing leaves the queue before ready
   assign issue         = (state == st_idle) && (q_count != '0);
   assign credit_return = issue;

   always_ff @(posedge clk)
   begin
      if (cmd_valid)
      begin
         q_op[wr_ptr]    <= cmd_op;
         q_index[wr_ptr] <= cmd_index;
         q_way[wr_ptr]   <= cmd_way;
         q_tag[wr_ptr]   <= cmd_tag;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         q_count <= '0;
      end
      else
      begin
         if (cmd_valid)
         begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (issue)
         begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         q_count <= q_count + CNT_W'(cmd_valid) - CNT_W'(issue);
      end
   end

   ////////////////////
   // state machine
   ////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state     <= st_reset;
         ready     <= 1'b0;
         sweep_idx <= '0;
      end
      else
      begin
         case (state)
            st_reset:
            begin
               sweep_idx <= '0;
               state     <= st_init;
            end
            st_init:
            begin
               sweep_idx <= sweep_idx + 1'b1;
               if (sweep_idx == SWEEP_LAST[`L1I_INDEX_W-1:0])
               begin
                  ready <= 1'b1;
                  state <= st_idle;
               end
            end
            st_idle:
            begin
               if (issue && (head_op == op_deallocate))
               begin
                  state <= st_read;
               end
            end
            // an earlier query may still be in flight, so wait for the deallocate's own bits
            st_read:
            begin
               if (pipe_vld[1] && pipe_dealloc[1])
               begin
                  state <= st_dealloc;
               end
            end
            st_dealloc:
            begin
               state <= st_idle;
            end
            default:
            begin
               state <= st_reset;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (issue && (head_op == op_deallocate))
      begin
         dealloc_index <= head_index;
      end
      if ((state == st_read) && pipe_vld[1])
      begin
         dealloc_ways <= match_all;
      end
   end

   ////////////////////
   // bank control
   ////////////////////

   always_comb
   begin
      wr_en_all = '0;
      case (state)
         st_init:
         begin
            wr_en_all = '1;
         end
         st_idle:
         begin
            if (issue && (head_op == op_allocate))
            begin
               wr_en_all[head_way] = 1'b1;
            end
            else if (issue && (head_op == op_invalidate))
            begin
               wr_en_all = '1;
            end
         end
         st_dealloc:
         begin
            wr_en_all = dealloc_ways;
         end
         default:
         begin
            wr_en_all = '0;
         end
      endcase
   end

   assign wr_en_lo = wr_en_all[1:0];
   assign wr_en_hi = wr_en_all[3:2];

   assign rd_en    = issue && ((head_op == op_query) || (head_op == op_deallocate));
   assign wr_valid = issue && (head_op == op_allocate);
   assign wr_tag   = head_tag;
   assign cmp_tag  = head_tag;

   assign addr = (state == st_init)    ? sweep_idx :
                 (state == st_dealloc) ? dealloc_index : head_index;

   ////////////////////
   // response path
   ////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pipe_vld     <= '0;
         pipe_dealloc <= '0;
         hit_hold     <= '0;
      end
      else
      begin
         pipe_vld     <= {pipe_vld[0], rd_en};
         pipe_dealloc <= {pipe_dealloc[0], issue && (head_op == op_deallocate)};
         if (pipe_vld[1])
         begin
            hit_hold <= hit_enc;
         end
      end
   end

   assign match_all = {match_hi, match_lo};

   // a multiple match is reported as a miss
   always_comb
   begin
      hit_enc = '0;
      if ($onehot(match_all))
      begin
         hit_enc.hit = 1'b1;
         for (int w = 0; w < `L1I_WAYS; w++)
         begin
            if (match_all[w])
            begin
               hit_enc.way = WAY_W'(w);
            end
         end
      end
   end

   assign resp_valid = pipe_vld[1];

   // the code leaves in the cycle the match bits arrive and is held afterwards
   assign resp_hit = pipe_vld[1] ? hit_enc : hit_hold;

endmodule

/* design/l1i_dir_top.sv */
`timescale 1ns/1ps
`include "l1i_dir_consts.svh"

module l1i_dir_top
   import l1i_dir_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         cmd_valid,
   input  dir_op_t                      cmd_op,
   input  logic [`L1I_INDEX_W-1:0]      cmd_index,
   input  logic [$clog2(`L1I_WAYS)-1:0] cmd_way,
   input  logic [`L1I_TAG_W-1:0]        cmd_tag,
   output logic                         credit_return,
   output logic                         resp_valid,
   output hit_code_t                    resp_hit,
   output logic                         ready
);

   logic                    rd_en;
   logic [1:0]              wr_en_lo;
   logic [1:0]              wr_en_hi;
   logic [`L1I_INDEX_W-1:0] addr;
   logic [`L1I_TAG_W-1:0]   wr_tag;
   logic                    wr_valid;
   logic [`L1I_TAG_W-1:0]   cmp_tag;
   logic [1:0]              match_lo;
   logic [1:0]              match_hi;

   l1i_dir_ctrl u_ctrl (
      .clk           (clk),
      .reset         (reset),
      .cmd_valid     (cmd_valid),
      .cmd_op        (cmd_op),
      .cmd_index     (cmd_index),
      .cmd_way       (cmd_way),
      .cmd_tag       (cmd_tag),
      .credit_return (credit_return),
      .ready         (ready),
      .rd_en         (rd_en),
      .wr_en_lo      (wr_en_lo),
      .wr_en_hi      (wr_en_hi),
      .addr          (addr),
      .wr_tag        (wr_tag),
      .wr_valid      (wr_valid),
      .cmp_tag       (cmp_tag),
      .match_lo      (match_lo),
      .match_hi      (match_hi),
      .resp_valid    (resp_valid),
      .resp_hit      (resp_hit)
   );

   // ways 0 and 1
   l1i_tag_bank u_bank_lo (
      .clk      (clk),
      .reset    (reset),
      .rd_en    (rd_en),
      .wr_en    (wr_en_lo),
      .addr     (addr),
      .wr_tag   (wr_tag),
      .wr_valid (wr_valid),
      .cmp_tag  (cmp_tag),
      .match    (match_lo)
   );

   // ways 2 and 3
   l1i_tag_bank u_bank_hi (
      .clk      (clk),
      .reset    (reset),
      .rd_en    (rd_en),
      .wr_en    (wr_en_hi),
      .addr     (addr),
      .wr_tag   (wr_tag),
      .wr_valid (wr_valid),
      .cmp_tag  (cmp_tag),
      .match    (match_hi)
   );

endmodule

/* test/l1i_dir_asserts.sv */
`timescale 1ns/1ps
`include "l1i_dir_consts.svh"

module l1i_dir_asserts
   import l1i_dir_pkg::*;
(
   input logic    clk,
   input logic    reset,
   input logic    cmd_valid,
   input dir_op_t cmd_op,
   input logic    credit_return,
   input logic    resp_valid,
   input logic    ready
);

   localparam int CNT_W = $clog2(`L1I_CREDITS + 1);
   localparam int PTR_W = $clog2(`L1I_CREDITS);

   // shadow of the command queue that keeps only the opcodes
   dir_op_t          op_q [`L1I_CREDITS];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] outstanding;
   logic             issue_rd;

   always_ff @(posedge clk)
   begin
      if (cmd_valid)
      begin
         op_q[wr_ptr] <= cmd_op;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         outstanding <= '0;
      end
      else
      begin
         if (cmd_valid)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (credit_return)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         outstanding <= outstanding + CNT_W'(cmd_valid) - CNT_W'(credit_return);
      end
   end

   // issue of a command that reads the banks and owes a response
   assign issue_rd = credit_return &&
                     ((op_q[rd_ptr] == op_query) || (op_q[rd_ptr] == op_deallocate));

   ////////////////////
   // protocol
   ////////////////////

   a_credit_sent: assert property (@(posedge clk) disable iff (reset)
      credit_return |-> (outstanding != '0))
      else $error("credit_return without an outstanding command");

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      outstanding <= CNT_W'(`L1I_CREDITS))
      else $error("more commands sent than credits allow");

   a_quiet_before_ready: assert property (@(posedge clk) disable iff (reset)
      !ready |-> (!credit_return && !resp_valid))
      else $error("credit_return or resp_valid before ready");

   a_ready_stays: assert property (@(posedge clk) disable iff (reset)
      ready |=> ready)
      else $error("ready dropped after it was raised");

   ////////////////////
   // response timing
   ////////////////////

   a_resp_after_issue: assert property (@(posedge clk) disable iff (reset)
      issue_rd |-> ##2 resp_valid)
      else $error("no resp_valid two cycles after a query or deallocate issue");

   a_resp_has_source: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> $past(issue_rd, 2))
      else $error("resp_valid without a matching issue two cycles earlier");

endmodule

bind l1i_dir_top l1i_dir_asserts u_asserts (
   .clk           (clk),
   .reset         (reset),
   .cmd_valid     (cmd_valid),
   .cmd_op        (cmd_op),
   .credit_return (credit_return),
   .resp_valid    (resp_valid),
   .ready         (ready)
);

/* test/l1i_dir_tb.sv */
`timescale 1ns/1ps
`include "l1i_dir_consts.svh"

module l1i_dir_tb
   import l1i_dir_pkg::*;
();

   localparam int SETS    = `L1I_SETS;
   localparam int WAYS    = `L1I_WAYS;
   localparam int CREDITS = `L1I_CREDITS;
   localparam int IDX_W   = `L1I_INDEX_W;
   localparam int TAG_W   = `L1I_TAG_W;
   localparam int WAY_W   = $clog2(`L1I_WAYS);
   localparam int TIMEOUT = 1000;

   typedef struct packed {
      dir_op_t          op;
      logic [IDX_W-1:0] index;
      logic [WAY_W-1:0] way;
      logic [TAG_W-1:0] tag;
   } dir_cmd_t;

   logic             clk;
   logic             reset;
   logic             cmd_valid;
   dir_op_t          cmd_op;
   logic [IDX_W-1:0] cmd_index;
   logic [WAY_W-1:0] cmd_way;
   logic [TAG_W-1:0] cmd_tag;
   logic             credit_return;
   logic             resp_valid;
   hit_code_t        resp_hit;
   logic             ready;

   // reference directory
   logic [TAG_W-1:0] ref_tag [SETS][WAYS];
   logic             ref_vld [SETS][WAYS];

   dir_cmd_t         pend_q [$];
   hit_code_t        exp_q  [$];
   int               credits;
   logic [31:0]      rng;

   l1i_dir_top dut (
      .clk           (clk),
      .reset         (reset),
      .cmd_valid     (cmd_valid),
      .cmd_op        (cmd_op),
      .cmd_index     (cmd_index),
      .cmd_way       (cmd_way),
      .cmd_tag       (cmd_tag),
      .credit_return (credit_return),
      .resp_valid    (resp_valid),
      .resp_hit      (resp_hit),
      .ready         (ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   function automatic logic [31:0] xorshift_next();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // a small pool of tags keeps hits frequent
   function automatic logic [TAG_W-1:0] pool_tag(input int n);
      return TAG_W'(32'h0c0f_fe00 + n);
   endfunction

   ////////////////////
   // reference model
   ////////////////////

   // exactly one matching way is a hit and anything else reads as zero
   function automatic hit_code_t expected_hit(input dir_cmd_t c);
      hit_code_t code;
      int        hits;
      code = '0;
      hits = 0;
      for (int w = 0; w < WAYS; w++)
      begin
         if (ref_vld[c.index][w] && (ref_tag[c.index][w] == c.tag))
         begin
            hits++;
            code.way = WAY_W'(w);
         end
      end
      if (hits == 1)
      begin
         code.hit = 1'b1;
      end
      else
      begin
         code = '0;
      end
      return code;
   endfunction

   function automatic void apply_cmd(input dir_cmd_t c);
      for (int w = 0; w < WAYS; w++)
      begin
         if ((c.op == op_invalidate) ||
             ((c.op == op_deallocate) && ref_vld[c.index][w] && (ref_tag[c.index][w] == c.tag)))
         begin
            ref_vld[c.index][w] = 1'b0;
         end
      end
      if (c.op == op_allocate)
      begin
         ref_tag[c.index][c.way] = c.tag;
         ref_vld[c.index][c.way] = 1'b1;
      end
   endfunction

   // commands take effect in queue order as credit_return pulses
   always @(negedge clk)
   begin
      dir_cmd_t  c;
      hit_code_t want;
      if (!reset && credit_return)
      begin
         if (pend_q.size() == 0)
            abort_run("credit returned with no command waiting in the queue");
         else
         begin
            c = pend_q.pop_front();
            credits++;
            if ((c.op == op_query) || (c.op == op_deallocate))
            begin
               exp_q.push_back(expected_hit(c));
            end
            apply_cmd(c);
         end
      end
      if (!reset && resp_valid)
      begin
         if (exp_q.size() == 0)
            abort_run("response with no query or deallocate outstanding");
         else
         begin
            want = exp_q.pop_front();
            assert (resp_hit == want)
            else abort_run($sformatf("Error resp_hit expected %h actual %h", want, resp_hit));
         end
      end
   end

   ////////////////////
   // stimulus
   ////////////////////

   task automatic send_cmd(input dir_op_t op, input int index, input int way,
                           input logic [TAG_W-1:0] tag);
      dir_cmd_t c;
      int       waited;
      waited = 0;
      while (credits == 0)
      begin
         cmd_valid = 1'b0;
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT)
            abort_run("timeout waiting for a credit");
      end
      c.op      = op;
      c.index   = IDX_W'(index);
      c.way     = WAY_W'(way);
      c.tag     = tag;
      cmd_valid = 1'b1;
      cmd_op    = c.op;
      cmd_index = c.index;
      cmd_way   = c.way;
      cmd_tag   = c.tag;
      pend_q.push_back(c);
      credits--;
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic wait_ready();
      int waited;
      waited = 0;
      while (!ready)
      begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT)
            abort_run("timeout waiting for ready after reset");
      end
      if (waited < SETS)
         abort_run("ready rose before the init sweep could cover every set");
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while ((credits != CREDITS) || (exp_q.size() != 0))
      begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT)
            abort_run("timeout waiting for credits and responses to come back");
      end
   endtask

   initial
   begin
      logic [31:0] r;
      dir_op_t     op;
      reset     = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = op_query;
      cmd_index = '0;
      cmd_way   = '0;
      cmd_tag   = '0;
      credits   = CREDITS;
      rng       = 32'd75757;
      for (int s = 0; s < SETS; s++)
      begin
         for (int w = 0; w < WAYS; w++)
         begin
            ref_tag[s][w] = '0;
            ref_vld[s][w] = 1'b0;
         end
      end
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      wait_ready();

      // the sweep leaves every set empty
      for (int s = 0; s < SETS; s++)
      begin
         send_cmd(op_query, s, 0, '0);
         send_cmd(op_query, s, 0, pool_tag(s % WAYS));
      end

      // one tag per way of set 5 followed by hits and misses around them
      for (int w = 0; w < WAYS; w++)
         send_cmd(op_allocate, 5, w, pool_tag(w));
      for (int w = 0; w < WAYS; w++)
         send_cmd(op_query, 5, 0, pool_tag(w));
      send_cmd(op_query, 5, 0, pool_tag(7));
      send_cmd(op_query, 6, 0, pool_tag(0));

      send_cmd(op_deallocate, 5, 0, pool_tag(1));
      send_cmd(op_query, 5, 0, pool_tag(1));
      send_cmd(op_deallocate, 5, 0, pool_tag(6));
      for (int w = 0; w < WAYS; w++)
         send_cmd(op_query, 5, 0, pool_tag(w));

      // invalidating set 5 must not touch set 6
      send_cmd(op_allocate, 6, 2, pool_tag(0));
      send_cmd(op_invalidate, 5, 0, '0);
      for (int w = 0; w < WAYS; w++)
         send_cmd(op_query, 5, 0, pool_tag(w));
      send_cmd(op_query, 6, 0, pool_tag(0));

      // same tag in two ways counts as a multiple match
      send_cmd(op_allocate, 9, 0, pool_tag(3));
      send_cmd(op_allocate, 9, 3, pool_tag(3));
      send_cmd(op_query, 9, 0, pool_tag(3));
      drain();

      // mixed bursts over a few sets with queries as the most common command
      for (int n = 0; n < 400; n++)
      begin
         r = xorshift_next();
         if (r[3:0] < 4'd6)
            op = op_query;
         else if (r[3:0] < 4'd11)
            op = op_allocate;
         else if (r[3:0] < 4'd14)
            op = op_deallocate;
         else
            op = op_invalidate;
         send_cmd(op, int'(r[6:4]), int'(r[10:9]), pool_tag(int'(r[8:7])));
      end
      drain();

      $display("Result: PASSED");
      $finish;
   end

endmodule

/* sim.f */
+incdir+design
design/l1i_dir_pkg.sv
design/l1i_tag_bank.sv
design/l1i_dir_ctrl.sv
design/l1i_dir_top.sv
test/l1i_dir_asserts.sv
test/l1i_dir_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the directory testbench with Verilator, runs it and judges the run from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f sim.f --top-module l1i_dir_tb \
   --Mdir obj_dir -o l1i_dir_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

# a run stopped by a bound assertion exits with an error and gets marked as failed
./obj_dir/l1i_dir_sim > sim.log 2>&1 \
   || echo "Result: FAILED" >> sim.log

cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
   || { echo "no pass message in sim.log"; exit 1; }
